// ==== hdl/uartRegPkg.sv ====
// UART control core register map
// Addresses, page and read selectors, and register field layouts
package uartRegPkg;

    // ----------------------------------------
    // Register addresses, banked ones at 1 to 4
    parameter logic [2:0] ADDR_CONTROL   = 3'd0;
    parameter logic [2:0] ADDR_PAGE_1    = 3'd1;
    parameter logic [2:0] ADDR_PAGE_2    = 3'd2;
    parameter logic [2:0] ADDR_PAGE_3    = 3'd3;
    parameter logic [2:0] ADDR_PAGE_4    = 3'd4;
    parameter logic [2:0] ADDR_STATUS1   = 3'd5;
    parameter logic [2:0] ADDR_STATUS2   = 3'd6;
    parameter logic [2:0] ADDR_DATA_PORT = 3'd7;

    // Encoding is {configEn, irqConfigEn, irqLvlEn}
    typedef enum logic [2:0] {
        PAGE_NORMAL  = 3'b000,
        PAGE_NONE    = 3'b001,
        PAGE_CONFIG  = 3'b100,
        PAGE_IRQ_CFG = 3'b110,
        PAGE_IRQ_LVL = 3'b111
    } regPage_e;

    // One entry per readable register
    typedef enum logic [4:0] {
        REG_NONE, REG_CONTROL, REG_MODE, REG_BAUD_HI, REG_BAUD_LO, REG_COMP,
        REG_IRQ_EN1, REG_IRQ_EN2, REG_MASK1, REG_MASK2, REG_TX_TRIG_HI,
        REG_TX_TRIG_LO, REG_IRQ_STAT1, REG_IRQ_STAT2, REG_RX_CNT_HI,
        REG_RX_CNT_LO, REG_STATUS1, REG_STATUS2, REG_RX_DATA
    } regSel_e;

    typedef struct packed {
        logic configEn;
        logic irqConfigEn;
        logic irqLvlEn;
        // Storage only, no clock select behind it
        logic clkSel;
        logic rxEn;
        logic txEn;
        logic rxRst;
        logic txRst;
    } uartCtrl_t;

    // Line mode, one-hot
    typedef enum logic [3:0] {
        NORMAL          = 4'b0001,
        AUTO_ECHO       = 4'b0010,
        LOCAL_LOOPBACK  = 4'b0100,
        REMOTE_LOOPBACK = 4'b1000
    } uartMode_e;

    typedef struct packed {
        uartMode_e mode;
        logic      bigEnd;
        logic      parEn;
        logic      parOdd;
        logic      reserved;
    } uartModeReg_t;

    // Single-cycle write strobes, high during the APB access phase
    typedef struct packed {
        logic mode;
        logic baudHi;
        logic baudLo;
        logic comp;
        logic irqEn1;
        logic irqEn2;
        logic txTrigHi;
        logic txTrigLo;
        logic irqStat1;
        logic irqStat2;
    } regWrStrb_t;

endpackage

// ==== hdl/uartIfPkg.sv ====
// UART control core side interfaces
// Baud generator, encoder, FIFO status and interrupt source bundles
package uartIfPkg;

    // ----------------------------------------
    // Toward the baud generator
    typedef struct packed {
        // Round-down acquisition period in clocks
        logic [15:0] period;
        logic [3:0]  roundUp;
        logic [3:0]  roundDown;
        // Acquisitions per bit, roundUp + roundDown
        logic [4:0]  acqPerBit;
    } baudCfg_t;

    // Toward the transmit and receive encoders
    typedef struct packed {
        logic       parityEn;
        logic       parityOdd;
        logic       bigEnd;
        // One-hot line mode
        logic [3:0] mode;
    } frameCfg_t;

    // ----------------------------------------
    // From the external FIFOs
    typedef struct packed {
        logic        txFull;
        logic        txEmpty;
        logic        rxFull;
        logic        rxEmpty;
        logic [15:0] txLevel;
        logic [15:0] rxLevel;
    } fifoStat_t;

    // InterruptStatus1 in the upper byte, InterruptStatus2 in the lower
    typedef struct packed {
        logic [1:0] rsvdHi;
        logic       rbrk;
        logic       tovr;
        logic       tnful;
        logic       ttrig;
        logic       rsvdLo;
        logic       tout;
        logic       parity;
        logic       framing;
        logic       over;
        logic       txFul;
        logic       txEmpty;
        logic       rxFull;
        logic       rxEmpty;
        logic       rxOvr;
    } irqSrc_t;

endpackage

// ==== hdl/uartBusDecode.sv ====
// UART APB access decode
// Holds UartControl, decodes the page and drives strobes and FIFO pulses
`timescale 1ns/100ps

module uartBusDecode
    import uartRegPkg::*;
    import uartIfPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  logic [2:0] paddr_i,
    input  logic [7:0] pwdata_i,
    input  fifoStat_t  fifo_i,
    output regWrStrb_t wrStrb_o,
    output logic [7:0] wrData_o,
    output regSel_e    rdSel_o,
    output uartCtrl_t  ctrl_o,
    output logic [7:0] txData_o,
    output logic       txFifoWe_o,
    output logic       rxFifoRd_o,
    output logic       txFifoClr_o,
    output logic       rxFifoClr_o
);

    logic     wrAcc;
    logic     rdAcc;
    regPage_e page;
    regSel_e  sel;
    logic     ctrlWe;
    logic     txPortWe;
    logic     rxPortRd;

    // Pick one of the four banked registers by address
    function automatic regSel_e pageSel(input logic [2:0] addr, input regSel_e r1,
                                        input regSel_e r2, input regSel_e r3,
                                        input regSel_e r4);
        case (addr)
            ADDR_PAGE_1: return r1;
            ADDR_PAGE_2: return r2;
            ADDR_PAGE_3: return r3;
            ADDR_PAGE_4: return r4;
            default:     return REG_NONE;
        endcase
    endfunction

    // Access phase, one cycle with no wait state
    assign wrAcc = psel_i & penable_i & pwrite_i;
    assign rdAcc = psel_i & penable_i & ~pwrite_i;
    assign wrData_o = pwdata_i;

    always_comb begin
        case ({ctrl_o.configEn, ctrl_o.irqConfigEn, ctrl_o.irqLvlEn})
            3'b100:  page = PAGE_CONFIG;
            3'b110:  page = PAGE_IRQ_CFG;
            3'b111:  page = PAGE_IRQ_LVL;
            3'b000:  page = PAGE_NORMAL;
            default: page = PAGE_NONE;
        endcase
    end

    // ----------------------------------------
    // Address plus page to register
    always_comb begin
        case (paddr_i)
            ADDR_CONTROL:   sel = REG_CONTROL;
            ADDR_STATUS1:   sel = REG_STATUS1;
            ADDR_STATUS2:   sel = REG_STATUS2;
            ADDR_DATA_PORT: sel = REG_RX_DATA;
            default: begin
                case (page)
                    PAGE_CONFIG:  sel = pageSel(paddr_i, REG_MODE, REG_BAUD_HI,
                                                REG_BAUD_LO, REG_COMP);
                    PAGE_IRQ_CFG: sel = pageSel(paddr_i, REG_IRQ_EN1, REG_IRQ_EN2,
                                                REG_MASK1, REG_MASK2);
                    // Receive trigger level slots stay empty
                    PAGE_IRQ_LVL: sel = pageSel(paddr_i, REG_NONE, REG_NONE,
                                                REG_TX_TRIG_HI, REG_TX_TRIG_LO);
                    PAGE_NORMAL:  sel = pageSel(paddr_i, REG_IRQ_STAT1, REG_IRQ_STAT2,
                                                REG_RX_CNT_HI, REG_RX_CNT_LO);
                    default:      sel = REG_NONE;
                endcase
            end
        endcase
    end

    // Write strobes, read-only registers get none
    always_comb begin
        wrStrb_o = '0;
        if (wrAcc) begin
            case (sel)
                REG_MODE:       wrStrb_o.mode     = 1'b1;
                REG_BAUD_HI:    wrStrb_o.baudHi   = 1'b1;
                REG_BAUD_LO:    wrStrb_o.baudLo   = 1'b1;
                REG_COMP:       wrStrb_o.comp     = 1'b1;
                REG_IRQ_EN1:    wrStrb_o.irqEn1   = 1'b1;
                REG_IRQ_EN2:    wrStrb_o.irqEn2   = 1'b1;
                REG_TX_TRIG_HI: wrStrb_o.txTrigHi = 1'b1;
                REG_TX_TRIG_LO: wrStrb_o.txTrigLo = 1'b1;
                REG_IRQ_STAT1:  wrStrb_o.irqStat1 = 1'b1;
                REG_IRQ_STAT2:  wrStrb_o.irqStat2 = 1'b1;
                default: ;
            endcase
        end
    end

    // Data port on address 7, full drops the byte and empty reads zero
    assign ctrlWe   = wrAcc && (sel == REG_CONTROL);
    assign txPortWe = wrAcc && (sel == REG_RX_DATA) && !fifo_i.txFull;
    assign rxPortRd = rdAcc && (sel == REG_RX_DATA) && !fifo_i.rxEmpty;
    assign rdSel_o  = (rdAcc && !((sel == REG_RX_DATA) && fifo_i.rxEmpty)) ? sel : REG_NONE;

    // ----------------------------------------
    // UartControl and FIFO pulses
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrl_o      <= '{configEn: 1'b1, default: 1'b0};
            txFifoClr_o <= 1'b0;
            rxFifoClr_o <= 1'b0;
            txFifoWe_o  <= 1'b0;
            rxFifoRd_o  <= 1'b0;
        end else begin
            // Reset bits become one-cycle clears and never stick
            txFifoClr_o <= ctrlWe & pwdata_i[0];
            rxFifoClr_o <= ctrlWe & pwdata_i[1];
            txFifoWe_o  <= txPortWe;
            rxFifoRd_o  <= rxPortRd;
            if (ctrlWe) begin
                ctrl_o <= {pwdata_i[7:2], 2'b00};
            end
        end
    end

    // Byte held for the FIFO write cycle
    always_ff @(posedge clk) begin
        if (txPortWe) begin
            txData_o <= pwdata_i;
        end
    end

endmodule

// ==== hdl/uartCfgRegs.sv ====
// UART configuration registers
// Mode, baud period and bit compensation toward baud generator and encoders
`timescale 1ns/100ps

module uartCfgRegs
    import uartRegPkg::*;
    import uartIfPkg::*;
#(
    parameter logic [15:0] DEFAULT_PERIOD = 16'd20,
    parameter logic [3:0]  DEFAULT_UP     = 4'd10,
    parameter logic [3:0]  DEFAULT_DOWN   = 4'd5
) (
    input  logic         clk,
    input  logic         rst,
    input  regWrStrb_t   wrStrb_i,
    input  logic [7:0]   wrData_i,
    output baudCfg_t     baud_o,
    output frameCfg_t    frame_o,
    output uartModeReg_t modeReg_o
);

    logic [15:0] period;
    logic [3:0]  roundUp;
    logic [3:0]  roundDown;
    logic [4:0]  acqPerBit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            // Normal mode, odd parity on, little-endian
            modeReg_o <= '{mode: NORMAL, bigEnd: 1'b0, parEn: 1'b1, parOdd: 1'b1,
                           reserved: 1'b0};
            period    <= DEFAULT_PERIOD;
            roundUp   <= DEFAULT_UP;
            roundDown <= DEFAULT_DOWN;
            acqPerBit <= {1'b0, DEFAULT_UP} + {1'b0, DEFAULT_DOWN};
        end else begin
            if (wrStrb_i.mode) begin
                modeReg_o.bigEnd   <= wrData_i[3];
                modeReg_o.parEn    <= wrData_i[2];
                modeReg_o.parOdd   <= wrData_i[1];
                modeReg_o.reserved <= wrData_i[0];
                // Mode only changes on a legal one-hot value
                if ($onehot(wrData_i[7:4])) begin
                    modeReg_o.mode <= uartMode_e'(wrData_i[7:4]);
                end
            end
            if (wrStrb_i.baudHi) begin
                period[15:8] <= wrData_i;
            end
            if (wrStrb_i.baudLo) begin
                period[7:0] <= wrData_i;
            end
            // Sum tracks the compensation write on the same edge
            if (wrStrb_i.comp) begin
                roundUp   <= wrData_i[7:4];
                roundDown <= wrData_i[3:0];
                acqPerBit <= {1'b0, wrData_i[7:4]} + {1'b0, wrData_i[3:0]};
            end
        end
    end

    // ----------------------------------------
    // Core side outputs
    assign baud_o.period    = period;
    assign baud_o.roundUp   = roundUp;
    assign baud_o.roundDown = roundDown;
    assign baud_o.acqPerBit = acqPerBit;

    assign frame_o.parityEn  = modeReg_o.parEn;
    assign frame_o.parityOdd = modeReg_o.parOdd;
    assign frame_o.bigEnd    = modeReg_o.bigEnd;
    assign frame_o.mode      = modeReg_o.mode;

endmodule

// ==== hdl/uartIrqCtrl.sv ====
// UART interrupt control
// Enables, sticky status with write-one-to-clear, TX trigger level and request
`timescale 1ns/100ps

module uartIrqCtrl
    import uartRegPkg::*;
    import uartIfPkg::*;
#(
    parameter int LEVEL_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  regWrStrb_t         wrStrb_i,
    input  logic [7:0]         wrData_i,
    input  fifoStat_t          fifo_i,
    input  logic               rxParityErr_i,
    input  logic               rxFrameErr_i,
    output irqSrc_t            irqEn_o,
    output irqSrc_t            irqStat_o,
    output logic [LEVEL_W-1:0] txTrig_o,
    output logic               ttrig_o,
    output logic               irq_o
);

    // Bits with a real source: TTRIG, PARITY, FRAMING and the four FIFO flags
    localparam logic [15:0] IRQ_IMPL = 16'h04DE;

    irqSrc_t     src;
    logic [15:0] w1c;

    // ----------------------------------------
    // Live interrupt sources
    always_comb begin
        src         = '0;
        src.ttrig   = fifo_i.txLevel[LEVEL_W-1:0] < txTrig_o;
        src.parity  = rxParityErr_i;
        src.framing = rxFrameErr_i;
        src.txFul   = fifo_i.txFull;
        src.txEmpty = fifo_i.txEmpty;
        src.rxFull  = fifo_i.rxFull;
        src.rxEmpty = fifo_i.rxEmpty;
    end

    assign ttrig_o = src.ttrig;

    // Clear mask from either status byte write
    assign w1c = {wrStrb_i.irqStat1 ? wrData_i : 8'h00,
                  wrStrb_i.irqStat2 ? wrData_i : 8'h00};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            irqEn_o   <= '0;
            irqStat_o <= '0;
            txTrig_o  <= '0;
        end else begin
            if (wrStrb_i.irqEn1) begin
                irqEn_o[15:8] <= wrData_i & IRQ_IMPL[15:8];
            end
            if (wrStrb_i.irqEn2) begin
                irqEn_o[7:0] <= wrData_i & IRQ_IMPL[7:0];
            end
            // A source set beats a clear in the same cycle
            irqStat_o <= (irqStat_o & ~w1c) | src;
            if (wrStrb_i.txTrigHi) begin
                txTrig_o[LEVEL_W-1 -: 8] <= wrData_i;
            end
            if (wrStrb_i.txTrigLo) begin
                txTrig_o[7:0] <= wrData_i;
            end
        end
    end

    // Request is any enabled pending bit
    assign irq_o = |(irqStat_o & irqEn_o);

endmodule

// ==== hdl/uartReadMux.sv ====
// UART read data selection
// Register read-back plus UartStatus1/2 and receive count assembly
`timescale 1ns/100ps

module uartReadMux
    import uartRegPkg::*;
    import uartIfPkg::*;
#(
    parameter int LEVEL_W = 16
) (
    input  regSel_e            rdSel_i,
    input  uartCtrl_t          ctrl_i,
    input  uartModeReg_t       modeReg_i,
    input  baudCfg_t           baud_i,
    input  irqSrc_t            irqEn_i,
    input  irqSrc_t            irqStat_i,
    input  logic [LEVEL_W-1:0] txTrig_i,
    input  logic               ttrig_i,
    input  fifoStat_t          fifo_i,
    input  logic [7:0]         rxData_i,
    output logic [7:0]         prdata_o
);

    logic [15:0] mask;

    // Mask is what would actually raise the request
    assign mask = irqStat_i & irqEn_i;

    always_comb begin
        case (rdSel_i)
            REG_CONTROL:    prdata_o = ctrl_i;
            REG_MODE:       prdata_o = modeReg_i;
            REG_BAUD_HI:    prdata_o = baud_i.period[15:8];
            REG_BAUD_LO:    prdata_o = baud_i.period[7:0];
            REG_COMP:       prdata_o = {baud_i.roundUp, baud_i.roundDown};
            REG_IRQ_EN1:    prdata_o = irqEn_i[15:8];
            REG_IRQ_EN2:    prdata_o = irqEn_i[7:0];
            REG_MASK1:      prdata_o = mask[15:8];
            REG_MASK2:      prdata_o = mask[7:0];
            REG_TX_TRIG_HI: prdata_o = txTrig_i[LEVEL_W-1 -: 8];
            REG_TX_TRIG_LO: prdata_o = txTrig_i[7:0];
            REG_IRQ_STAT1:  prdata_o = irqStat_i[15:8];
            REG_IRQ_STAT2:  prdata_o = irqStat_i[7:0];
            // Received byte count is the RX FIFO level
            REG_RX_CNT_HI:  prdata_o = fifo_i.rxLevel[LEVEL_W-1 -: 8];
            REG_RX_CNT_LO:  prdata_o = fifo_i.rxLevel[7:0];
            // TTRIG sits at bit 5
            REG_STATUS1:    prdata_o = {2'b00, ttrig_i, 5'b00000};
            REG_STATUS2:    prdata_o = {3'b000, fifo_i.txFull, fifo_i.txEmpty,
                                        fifo_i.rxFull, fifo_i.rxEmpty, 1'b0};
            REG_RX_DATA:    prdata_o = rxData_i;
            default:        prdata_o = 8'h00;
        endcase
    end

endmodule

// ==== hdl/uartCtrlTop.sv ====
// UART host-side control core
// APB register map driving the baud generator, encoders and external FIFOs
`timescale 1ns/100ps

module uartCtrlTop
    import uartRegPkg::*;
    import uartIfPkg::*;
#(
    parameter logic [15:0] DEFAULT_PERIOD = 16'd20,
    parameter logic [3:0]  DEFAULT_UP     = 4'd10,
    parameter logic [3:0]  DEFAULT_DOWN   = 4'd5,
    parameter int          LEVEL_W        = 16
) (
    input  logic       clk,
    input  logic       rst,
    // APB slave
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  logic [2:0] paddr_i,
    input  logic [7:0] pwdata_i,
    output logic [7:0] prdata_o,
    // Core side
    output baudCfg_t   baud_o,
    output frameCfg_t  frame_o,
    // FIFOs
    input  fifoStat_t  fifo_i,
    output logic [7:0] txData_o,
    output logic       txFifoWe_o,
    input  logic [7:0] rxData_i,
    output logic       rxFifoRd_o,
    output logic       txFifoClr_o,
    output logic       rxFifoClr_o,
    // Errors, enables, interrupt
    input  logic       rxParityErr_i,
    input  logic       rxFrameErr_i,
    output logic       txEn_o,
    output logic       rxEn_o,
    output logic       irq_o
);

    regWrStrb_t         wrStrb;
    logic [7:0]         wrData;
    regSel_e            rdSel;
    uartCtrl_t          ctrl;
    uartModeReg_t       modeReg;
    irqSrc_t            irqEn;
    irqSrc_t            irqStat;
    logic [LEVEL_W-1:0] txTrig;
    logic               ttrig;

    assign txEn_o = ctrl.txEn;
    assign rxEn_o = ctrl.rxEn;

    // ----------------------------------------
    // Bus side
    uartBusDecode uBusDecode (
        .clk, .rst, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i, .fifo_i,
        .wrStrb_o (wrStrb),
        .wrData_o (wrData),
        .rdSel_o  (rdSel),
        .ctrl_o   (ctrl),
        .txData_o, .txFifoWe_o, .rxFifoRd_o, .txFifoClr_o, .rxFifoClr_o
    );

    uartReadMux #(.LEVEL_W(LEVEL_W)) uReadMux (
        .rdSel_i   (rdSel),
        .ctrl_i    (ctrl),
        .modeReg_i (modeReg),
        .baud_i    (baud_o),
        .irqEn_i   (irqEn),
        .irqStat_i (irqStat),
        .txTrig_i  (txTrig),
        .ttrig_i   (ttrig),
        .fifo_i, .rxData_i, .prdata_o
    );

    // ----------------------------------------
    // Register banks
    uartCfgRegs #(
        .DEFAULT_PERIOD (DEFAULT_PERIOD),
        .DEFAULT_UP     (DEFAULT_UP),
        .DEFAULT_DOWN   (DEFAULT_DOWN)
    ) uCfgRegs (
        .clk, .rst,
        .wrStrb_i  (wrStrb),
        .wrData_i  (wrData),
        .baud_o, .frame_o,
        .modeReg_o (modeReg)
    );

    uartIrqCtrl #(.LEVEL_W(LEVEL_W)) uIrqCtrl (
        .clk, .rst,
        .wrStrb_i  (wrStrb),
        .wrData_i  (wrData),
        .fifo_i, .rxParityErr_i, .rxFrameErr_i,
        .irqEn_o   (irqEn),
        .irqStat_o (irqStat),
        .txTrig_o  (txTrig),
        .ttrig_o   (ttrig),
        .irq_o
    );

endmodule

// ==== sim/uartCtrlTb_chk.sv ====
// FIFO strobe checker bound into the APB decode
// Data port pulses against full and empty flags, and clear pulse width
`timescale 1ns/100ps

module uartCtrlTb_chk
    import uartRegPkg::*;
    import uartIfPkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pwrite_i,
    input logic [2:0] paddr_i,
    input fifoStat_t  fifo_i,
    input logic       txFifoWe_o,
    input logic       rxFifoRd_o,
    input logic       txFifoClr_o,
    input logic       rxFifoClr_o
);

    int   failCount = 0;
    logic portAcc;

    // Access phase on the data port address
    assign portAcc = psel_i && penable_i && (paddr_i == ADDR_DATA_PORT);

    // FIFO write only after a data port write that saw room
    txWeLegal: assert property (@(posedge clk) disable iff (!rst)
        txFifoWe_o |-> $past(portAcc && pwrite_i && !fifo_i.txFull))
        else begin
            $error("txFifoWe_o without a write to a non-full FIFO");
            failCount++;
        end

    // Pop only after a data port read with data present
    rxRdLegal: assert property (@(posedge clk) disable iff (!rst)
        rxFifoRd_o |-> $past(portAcc && !pwrite_i && !fifo_i.rxEmpty))
        else begin
            $error("rxFifoRd_o without a read from a non-empty FIFO");
            failCount++;
        end

    // ----------------------------------------
    // Clears are single-cycle
    txClrWidth: assert property (@(posedge clk) disable iff (!rst)
        txFifoClr_o |=> !txFifoClr_o)
        else begin
            $error("txFifoClr_o held for more than one cycle");
            failCount++;
        end

    rxClrWidth: assert property (@(posedge clk) disable iff (!rst)
        rxFifoClr_o |=> !rxFifoClr_o)
        else begin
            $error("rxFifoClr_o held for more than one cycle");
            failCount++;
        end

endmodule

bind uartBusDecode uartCtrlTb_chk uBusChk (
    .clk, .rst, .psel_i, .penable_i, .pwrite_i, .paddr_i, .fifo_i,
    .txFifoWe_o, .rxFifoRd_o, .txFifoClr_o, .rxFifoClr_o
);

// ==== include/uartCtrlTbTasks.svh ====
// UART control core directed tests
// Each task drives one feature through APB and checks the response
`ifndef UART_CTRL_TB_TASKS_SVH
`define UART_CTRL_TB_TASKS_SVH

// ----------------------------------------
// Reset values on the config page and on the core side outputs
task automatic resetDefaults();
    logic [7:0] rd;
    apbRead(ADDR_CONTROL, rd);
    checkVal("UartControl", rd, 8'h80);
    // Normal mode, little-endian, parity on and odd
    apbRead(ADDR_PAGE_1, rd);
    checkVal("UartMode", rd, 8'h16);
    apbRead(ADDR_PAGE_2, rd);
    checkVal("BaudPeriodHi", rd, 8'h00);
    apbRead(ADDR_PAGE_3, rd);
    checkVal("BaudPeriodLo", rd, 8'h14);
    // Up 10 in the high nibble, down 5 in the low
    apbRead(ADDR_PAGE_4, rd);
    checkVal("BitCompensation", rd, 8'hA5);
    @(negedge clk);
    checkVal("baud_o.period", baud.period, 32'd20);
    checkVal("baud_o.roundUp", baud.roundUp, 32'd10);
    checkVal("baud_o.roundDown", baud.roundDown, 32'd5);
    checkVal("baud_o.acqPerBit", baud.acqPerBit, 32'd15);
    checkVal("frame_o.parityEn", frame.parityEn, 32'd1);
    checkVal("frame_o.parityOdd", frame.parityOdd, 32'd1);
    checkVal("frame_o.bigEnd", frame.bigEnd, 32'd0);
    checkVal("frame_o.mode", frame.mode, 32'b0001);
    checkVal("txEn_o", txEn, 32'd0);
    checkVal("rxEn_o", rxEn, 32'd0);
    checkVal("irq_o", irq, 32'd0);
endtask

// ----------------------------------------
// Random baud setup then a normal page write that must miss it
task automatic pagedConfig();
    logic [31:0] rnd;
    logic [15:0] period;
    logic [3:0]  up;
    logic [3:0]  down;
    logic [7:0]  rd;
    rnd    = lcgNext();
    period = rnd[23:8];
    rnd    = lcgNext();
    up     = rnd[19:16];
    down   = rnd[11:8];
    apbWrite(ADDR_CONTROL, 8'h80);
    apbWrite(ADDR_PAGE_2, period[15:8]);
    apbWrite(ADDR_PAGE_3, period[7:0]);
    apbWrite(ADDR_PAGE_4, {up, down});
    @(negedge clk);
    checkVal("baud_o.period", baud.period, period);
    checkVal("baud_o.roundUp", baud.roundUp, up);
    checkVal("baud_o.roundDown", baud.roundDown, down);
    checkVal("baud_o.acqPerBit", baud.acqPerBit, 32'(up) + 32'(down));
    apbRead(ADDR_PAGE_2, rd);
    checkVal("BaudPeriodHi", rd, period[15:8]);
    apbRead(ADDR_PAGE_4, rd);
    checkVal("BitCompensation", rd, {up, down});
    // Address 2 is InterruptStatus2 on the normal page
    apbWrite(ADDR_CONTROL, 8'h00);
    apbWrite(ADDR_PAGE_2, ~period[15:8]);
    @(negedge clk);
    checkVal("baud_o.period", baud.period, period);
endtask

// ----------------------------------------
// Enabled PARITY raises irq, disabled FRAMING only sets status
task automatic interruptFlow();
    logic [7:0] rd;
    apbWrite(ADDR_CONTROL, 8'hC0);
    // PARITY is bit 7 of InterruptEnable2
    apbWrite(ADDR_PAGE_2, 8'h80);
    @(posedge clk);
    #1;
    rxParityErr = 1'b1;
    @(negedge clk);
    checkVal("irq_o", irq, 32'd0);
    @(posedge clk);
    #1;
    rxParityErr = 1'b0;
    @(negedge clk);
    checkVal("irq_o", irq, 32'd1);
    apbRead(ADDR_PAGE_4, rd);
    checkVal("InterruptMask2", rd, 8'h80);
    apbWrite(ADDR_CONTROL, 8'h00);
    apbRead(ADDR_PAGE_2, rd);
    checkVal("InterruptStatus2", rd, 8'h80);
    apbWrite(ADDR_PAGE_2, 8'h80);
    @(negedge clk);
    checkVal("irq_o", irq, 32'd0);
    apbRead(ADDR_PAGE_2, rd);
    checkVal("InterruptStatus2", rd, 8'h00);
    // FRAMING at bit 6 stays disabled
    @(posedge clk);
    #1;
    rxFrameErr = 1'b1;
    @(posedge clk);
    #1;
    rxFrameErr = 1'b0;
    apbRead(ADDR_PAGE_2, rd);
    checkVal("InterruptStatus2", rd, 8'h40);
    checkVal("irq_o", irq, 32'd0);
    apbWrite(ADDR_PAGE_2, 8'h40);
endtask

// ----------------------------------------
// TTRIG only while txLevel is below the trigger level
task automatic txTrigger();
    logic [7:0] rd;
    apbWrite(ADDR_CONTROL, 8'hE0);
    apbWrite(ADDR_PAGE_3, 8'h00);
    apbWrite(ADDR_PAGE_4, 8'h10);
    apbRead(ADDR_PAGE_4, rd);
    checkVal("TxTriggerLo", rd, 8'h10);
    fifo.txLevel = 16'h0005;
    apbRead(ADDR_STATUS1, rd);
    checkVal("UartStatus1", rd, 8'h20);
    apbWrite(ADDR_CONTROL, 8'h00);
    // TTRIG is bit 2 of InterruptStatus1
    apbRead(ADDR_PAGE_1, rd);
    checkVal("InterruptStatus1.TTRIG", rd[2], 32'd1);
    fifo.txLevel = 16'h0010;
    apbRead(ADDR_STATUS1, rd);
    checkVal("UartStatus1", rd, 8'h00);
    fifo.txLevel = 16'h0123;
    apbRead(ADDR_STATUS1, rd);
    checkVal("UartStatus1", rd, 8'h00);
    apbWrite(ADDR_PAGE_1, 8'h04);
endtask

// ----------------------------------------
// Data port pushes and pops with full and empty drops
task automatic dataPorts();
    logic [31:0] rnd;
    logic [7:0]  wrByte;
    logic [7:0]  rd;
    int          weStart;
    int          rdStart;
    rnd     = lcgNext();
    wrByte  = rnd[15:8];
    weStart = txWeCount;
    apbWrite(ADDR_DATA_PORT, wrByte);
    waitCycles(3);
    checkVal("txFifoWe_o pulses", txWeCount - weStart, 32'd1);
    checkVal("txData_o", txWeData, wrByte);
    fifo.txFull = 1'b1;
    weStart     = txWeCount;
    apbWrite(ADDR_DATA_PORT, ~wrByte);
    waitCycles(3);
    fifo.txFull = 1'b0;
    checkVal("txFifoWe_o pulses while full", txWeCount - weStart, 32'd0);
    rnd     = lcgNext();
    // Nonzero byte so the empty read stands apart from it
    rxData  = rnd[23:16] | 8'h01;
    rdStart = rxRdCount;
    apbRead(ADDR_DATA_PORT, rd);
    checkVal("prdata_o RxDataPort", rd, rxData);
    waitCycles(3);
    checkVal("rxFifoRd_o pulses", rxRdCount - rdStart, 32'd1);
    fifo.rxEmpty = 1'b1;
    rdStart      = rxRdCount;
    apbRead(ADDR_DATA_PORT, rd);
    checkVal("prdata_o RxDataPort while empty", rd, 8'h00);
    waitCycles(3);
    fifo.rxEmpty = 1'b0;
    checkVal("rxFifoRd_o pulses while empty", rxRdCount - rdStart, 32'd0);
endtask

// ----------------------------------------
// TxRst and RxRst self-clear after one pulse each
task automatic fifoClears();
    logic [7:0] rd;
    int         txStart;
    int         rxStart;
    txStart = txClrCount;
    rxStart = rxClrCount;
    // RxEn, TxEn, RxRst and TxRst all set
    apbWrite(ADDR_CONTROL, 8'h0F);
    waitCycles(3);
    checkVal("txFifoClr_o pulses", txClrCount - txStart, 32'd1);
    checkVal("rxFifoClr_o pulses", rxClrCount - rxStart, 32'd1);
    apbRead(ADDR_CONTROL, rd);
    checkVal("UartControl", rd, 8'h0C);
    @(negedge clk);
    checkVal("txEn_o", txEn, 32'd1);
    checkVal("rxEn_o", rxEn, 32'd1);
endtask

`endif

// ==== sim/uartCtrlTb.sv ====
// UART control core testbench
// Drives the APB map, FIFO status and error inputs and checks the responses
`timescale 1ns/100ps

module uartCtrlTb
    import uartRegPkg::*;
    import uartIfPkg::*;
();

    // Six tests of well under 150 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [2:0] paddr;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    baudCfg_t   baud;
    frameCfg_t  frame;
    fifoStat_t  fifo;
    logic [7:0] txData;
    logic       txFifoWe;
    logic [7:0] rxData;
    logic       rxFifoRd;
    logic       txFifoClr;
    logic       rxFifoClr;
    logic       rxParityErr;
    logic       rxFrameErr;
    logic       txEn;
    logic       rxEn;
    logic       irq;

    int          errCount   = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          assertFails;
    // Pulse counters for the FIFO side strobes
    int          txWeCount  = 0;
    int          rxRdCount  = 0;
    int          txClrCount = 0;
    int          rxClrCount = 0;
    logic [7:0]  txWeData;
    logic [31:0] lcgState;

    uartCtrlTop dut_i (
        .clk, .rst,
        .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
        .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
        .baud_o (baud), .frame_o (frame), .fifo_i (fifo),
        .txData_o (txData), .txFifoWe_o (txFifoWe),
        .rxData_i (rxData), .rxFifoRd_o (rxFifoRd),
        .txFifoClr_o (txFifoClr), .rxFifoClr_o (rxFifoClr),
        .rxParityErr_i (rxParityErr), .rxFrameErr_i (rxFrameErr),
        .txEn_o (txEn), .rxEn_o (rxEn), .irq_o (irq)
    );

    // ----------------------------------------
    // Clock and run limit
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run stopped, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Strobes sampled mid-cycle, away from the edge
    always @(negedge clk) begin
        if (txFifoWe) begin
            txWeCount++;
            txWeData = txData;
        end
        if (rxFifoRd) begin
            rxRdCount++;
        end
        if (txFifoClr) begin
            txClrCount++;
        end
        if (rxFifoClr) begin
            rxClrCount++;
        end
    end

    // ----------------------------------------
    // Helpers
    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Setup then one access cycle, no wait states
    task automatic apbWrite(input logic [2:0] addr, input logic [7:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // Register takes the byte on this edge
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [2:0] addr, output logic [7:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // prdata is combinational during the access phase
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    `include "uartCtrlTbTasks.svh"

    // ----------------------------------------
    // Test sequence
    initial begin
        lcgState    = 32'h47c7_3cf3;
        rst         = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 3'd0;
        pwdata      = 8'h00;
        fifo        = '0;
        rxData      = 8'h00;
        rxParityErr = 1'b0;
        rxFrameErr  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;

        resetDefaults();
        pagedConfig();
        interruptFlow();
        txTrigger();
        dataPorts();
        fifoClears();
        waitCycles(2);

        assertFails = dut_i.uBusDecode.uBusChk.failCount;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checkCount, errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+include
hdl/uartRegPkg.sv
hdl/uartIfPkg.sv
hdl/uartBusDecode.sv
hdl/uartCfgRegs.sv
hdl/uartIrqCtrl.sv
hdl/uartReadMux.sv
hdl/uartCtrlTop.sv
sim/uartCtrlTb_chk.sv
sim/uartCtrlTb.sv

// ==== Bender.yml ====
package:
  name: uart_ctrl_core

sources:
  - hdl/uartRegPkg.sv
  - hdl/uartIfPkg.sv
  - hdl/uartBusDecode.sv
  - hdl/uartCfgRegs.sv
  - hdl/uartIrqCtrl.sv
  - hdl/uartReadMux.sv
  - hdl/uartCtrlTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/uartCtrlTb_chk.sv
      - sim/uartCtrlTb.sv
